/* rv32BranchUnit.f */
+incdir+include
source/branchUnitTypes.sv
source/branchDecoder.sv
source/branchALU.sv
source/branchUnitTop.sv
verification/branchUnitTb.sv

/* verification/branchUnitTb.sv */
`default_nettype none

`include "rv32BranchUnit_params.svh"

module branchUnitTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ITEM_COUNT = 200;
	localparam int PHASE1_COUNT = 40; // Items sent with outReady held high
	localparam int TIMEOUT_CYCLES = 3 * ITEM_COUNT + 50;

	logic clock;
	logic arstN;
	logic inValid;
	logic inReady;
	branchUnitTypes::Instruction_t instruction;
	branchUnitTypes::Word_t pcOfInstruction;
	branchUnitTypes::Word_t rs1;
	branchUnitTypes::Word_t rs2;
	logic outValid;
	logic outReady;
	branchUnitTypes::Word_t programCounterInput;
	branchUnitTypes::Word_t branchALUOutput;
	logic linkWrite;
	logic branchALUBadFunct3;

	// Scoreboard, filled at input acceptance
	branchUnitTypes::Word_t expectedPc[$];
	branchUnitTypes::Word_t expectedLink[$];
	logic expectedLinkWrite[$];
	logic expectedBad[$];

	logic [15:0] lfsrState = 16'd48600;
	int cycleCount = 0;
	int sentCount = 0;
	int builtCount = 0;
	int recvCount = 0;
	int firstAcceptCycle = 0;
	int badCount = 0;
	int linkCount = 0;
	int takenCount = 0;

	// Output snapshot while the sink stalls
	logic heldValid = 1'b0;
	branchUnitTypes::Word_t heldPc;
	branchUnitTypes::Word_t heldLink;
	logic heldLinkWrite;
	logic heldBad;

	branchUnitTop uut
	(
		.clock, .arstN,
		.inValid, .inReady, .instruction, .pcOfInstruction, .rs1, .rs2,
		.outValid, .outReady, .programCounterInput, .branchALUOutput,
		.linkWrite, .branchALUBadFunct3
	);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsrStep(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	function automatic logic [31:0] takeBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsrState = lfsrStep(lfsrState);
			value = {value[30:0], lfsrState[0]};
		end
		return value;
	endfunction

	// Expected next PC, link value and flags from the RV32I rules
	function automatic void referenceModel
	(
		input branchUnitTypes::Instruction_t word,
		input branchUnitTypes::Word_t pc,
		input branchUnitTypes::Word_t a,
		input branchUnitTypes::Word_t b,
		output branchUnitTypes::Word_t nextPc,
		output branchUnitTypes::Word_t link,
		output logic doLink,
		output logic bad
	);
		branchUnitTypes::Word_t immI;
		branchUnitTypes::Word_t immJ;
		branchUnitTypes::Word_t immB;
		branchUnitTypes::Word_t seq;
		branchUnitTypes::Word_t flipA;
		branchUnitTypes::Word_t flipB;
		logic signed [20:0] rawJ;
		logic signed [12:0] rawB;
		logic [6:0] opcode;
		logic [2:0] f3;
		logic taken;
		opcode = word[6:0];
		f3 = word[14:12];
		immI = branchUnitTypes::Word_t'($signed(word) >>> 20);
		rawJ = {word[31], word[19:12], word[20], word[30:21], 1'b0};
		rawB = {word[31], word[7], word[30:25], word[11:8], 1'b0};
		immJ = branchUnitTypes::Word_t'(rawJ);
		immB = branchUnitTypes::Word_t'(rawB);
		seq = pc + branchUnitTypes::Word_t'(`PC_STEP);
		flipA = a ^ 32'h8000_0000; // Signed order as unsigned order
		flipB = b ^ 32'h8000_0000;
		case (f3)
			3'b000: taken = a == b;
			3'b001: taken = a != b;
			3'b100: taken = flipA < flipB;
			3'b101: taken = flipA >= flipB;
			3'b110: taken = a < b;
			3'b111: taken = a >= b;
			default: taken = 1'b0;
		endcase
		bad = (opcode == `OPCODE_BRANCH) && ((f3 == 3'b010) || (f3 == 3'b011));
		doLink = (opcode == `OPCODE_JAL) || (opcode == `OPCODE_JALR);
		link = seq;
		if (opcode == `OPCODE_JAL)
			nextPc = pc + immJ;
		else if (opcode == `OPCODE_JALR)
		begin
			nextPc = a + immI;
			nextPc[0] = 1'b0;
		end
		else if ((opcode == `OPCODE_BRANCH) && taken)
			nextPc = pc + immB;
		else
			nextPc = seq;
	endfunction

	task automatic checkWord(input string name, input branchUnitTypes::Word_t actual,
		input branchUnitTypes::Word_t expected);
		if (actual !== expected)
		begin
			$display("Mismatch at time %0t: %s is %h, expected %h", $time, name, actual, expected);
			$display("*** FAILED ***");
			$fatal(1, "Stopping at first error");
		end
	endtask

	task automatic checkFlag(input string name, input logic actual, input logic expected);
		if (actual !== expected)
		begin
			$display("Mismatch at time %0t: %s is %b, expected %b", $time, name, actual, expected);
			$display("*** FAILED ***");
			$fatal(1, "Stopping at first error");
		end
	endtask

	task automatic checkCycle(input string name, input int actual, input int expected);
		if (actual != expected)
		begin
			$display("Mismatch at time %0t: %s is %0d, expected %0d", $time, name, actual, expected);
			$display("*** FAILED ***");
			$fatal(1, "Stopping at first error");
		end
	endtask

	// Random item onto the input port
	task automatic buildItem();
		branchUnitTypes::Instruction_t word;
		branchUnitTypes::Word_t a;
		branchUnitTypes::Word_t b;
		branchUnitTypes::Word_t pc;
		logic [2:0] kind;
		logic [1:0] relation;
		word = takeBits(32);
		kind = 3'(takeBits(3));
		case (kind)
			3'd0, 3'd1: word[6:0] = `OPCODE_JAL;
			3'd2: word[6:0] = `OPCODE_JALR;
			3'd3, 3'd4, 3'd5: word[6:0] = `OPCODE_BRANCH;
			default: ; // Random opcode, INCREMENT mostly
		endcase
		a = takeBits(32);
		relation = 2'(takeBits(2));
		b = takeBits(32);
		if (relation == 2'd0)
			b = a;
		else if (relation == 2'd1)
			b[31] = ~a[31]; // Opposite sign
		pc = takeBits(32);
		pc[1:0] = 2'b00;
		instruction <= word;
		pcOfInstruction <= pc;
		rs1 <= a;
		rs2 <= b;
		inValid <= 1'b1;
		builtCount++;
	endtask

	task automatic recordAccepted();
		branchUnitTypes::Word_t refPc;
		branchUnitTypes::Word_t refLink;
		logic refLinkWrite;
		logic refBad;
		referenceModel(instruction, pcOfInstruction, rs1, rs2, refPc, refLink, refLinkWrite, refBad);
		expectedPc.push_back(refPc);
		expectedLink.push_back(refLink);
		expectedLinkWrite.push_back(refLinkWrite);
		expectedBad.push_back(refBad);
		if (sentCount == 0)
			firstAcceptCycle = cycleCount;
		if (refBad)
			badCount++;
		if (refLinkWrite)
			linkCount++;
		if ((instruction[6:0] == `OPCODE_BRANCH) && (refPc != refLink))
			takenCount++;
		sentCount++;
	endtask

	initial
	begin
		arstN = 1'b0;
		inValid = 1'b0;
		outReady = 1'b1;
		instruction = '0;
		pcOfInstruction = '0;
		rs1 = '0;
		rs2 = '0;
		repeat (4) @(posedge clock);
		arstN <= 1'b1;
		@(posedge clock);
		checkFlag("outValid", outValid, 1'b0);
		checkFlag("linkWrite", linkWrite, 1'b0);
		checkFlag("branchALUBadFunct3", branchALUBadFunct3, 1'b0);
		checkFlag("inReady", inReady, 1'b1);

		// Back to back items, sink always ready
		buildItem();
		while (sentCount < PHASE1_COUNT)
		begin
			@(posedge clock);
			checkFlag("inReady", inReady, 1'b1);
			recordAccepted();
			if (builtCount < PHASE1_COUNT)
				buildItem();
			else
				inValid <= 1'b0;
		end
		wait (recvCount == PHASE1_COUNT);

		// Random gaps and random back-pressure
		while (sentCount < ITEM_COUNT)
		begin
			@(posedge clock);
			if (inValid && inReady)
				recordAccepted();
			if (!inValid || inReady)
			begin
				if ((builtCount < ITEM_COUNT) && (takeBits(2) != 32'd0))
					buildItem();
				else
					inValid <= 1'b0;
			end
			outReady <= 1'(takeBits(1));
		end
		@(posedge clock);
		outReady <= 1'b1;
		wait (recvCount == ITEM_COUNT);
		@(posedge clock);
		if ((badCount == 0) || (linkCount == 0) || (takenCount == 0))
		begin
			$display("Stimulus never produced a bad funct3, a jump and a taken branch");
			$display("*** FAILED ***");
			$fatal(1, "Incomplete stimulus");
		end
		else
		begin
			$display("*** PASSED ***");
			$finish;
		end
	end

	// Output checker
	always @(posedge clock)
	begin
		if (arstN)
		begin
			if (heldValid)
			begin
				checkFlag("outValid", outValid, 1'b1);
				checkWord("programCounterInput", programCounterInput, heldPc);
				checkWord("branchALUOutput", branchALUOutput, heldLink);
				checkFlag("linkWrite", linkWrite, heldLinkWrite);
				checkFlag("branchALUBadFunct3", branchALUBadFunct3, heldBad);
			end
			if (outValid && outReady)
			begin
				if (expectedPc.size() == 0)
				begin
					$display("Output transfer at time %0t with no item outstanding", $time);
					$display("*** FAILED ***");
					$fatal(1, "Extra output item");
				end
				if (recvCount < PHASE1_COUNT)
					checkCycle("output cycle", cycleCount, firstAcceptCycle + 2 + recvCount);
				checkWord("programCounterInput", programCounterInput, expectedPc.pop_front());
				checkWord("branchALUOutput", branchALUOutput, expectedLink.pop_front());
				checkFlag("linkWrite", linkWrite, expectedLinkWrite.pop_front());
				checkFlag("branchALUBadFunct3", branchALUBadFunct3, expectedBad.pop_front());
				recvCount++;
			end
			heldValid = outValid && !outReady;
			heldPc = programCounterInput;
			heldLink = branchALUOutput;
			heldLinkWrite = linkWrite;
			heldBad = branchALUBadFunct3;
		end
	end

	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES)
		begin
			$display("Timeout after %0d cycles, %0d of %0d items received",
				cycleCount, recvCount, ITEM_COUNT);
			$display("*** FAILED ***");
			$fatal(1, "Simulation timed out");
		end
	end

endmodule

`default_nettype wire

/* source/branchUnitTop.sv */
`default_nettype none

module branchUnitTop
(
	input logic clock,
	input logic arstN,

	// Instruction in
	input logic inValid,
	output logic inReady,
	input branchUnitTypes::Instruction_t instruction,
	input branchUnitTypes::Word_t pcOfInstruction,
	input branchUnitTypes::Word_t rs1,
	input branchUnitTypes::Word_t rs2,

	// Next PC and link value out
	output logic outValid,
	input logic outReady,
	output branchUnitTypes::Word_t programCounterInput,
	output branchUnitTypes::Word_t branchALUOutput,
	output logic linkWrite,
	output logic branchALUBadFunct3
);

	// Decode to branch stage
	logic decValid;
	logic decReady;
	branchUnitTypes::BranchALUMode_t branchALUMode;
	branchUnitTypes::Funct3_t funct3;
	branchUnitTypes::Word_t immediateI;
	branchUnitTypes::Word_t immediateJ;
	branchUnitTypes::Word_t immediateB;
	branchUnitTypes::Word_t decPc;
	branchUnitTypes::Word_t decRs1;
	branchUnitTypes::Word_t decRs2;

	branchDecoder decoder
	(
		.clock, .arstN,
		.inValid, .inReady, .instruction, .pcOfInstruction, .rs1, .rs2,
		.decValid, .decReady, .branchALUMode, .funct3,
		.immediateI, .immediateJ, .immediateB,
		.decPc, .decRs1, .decRs2
	);

	branchALU alu
	(
		.clock, .arstN,
		.decValid, .decReady, .branchALUMode, .funct3,
		.immediateI, .immediateJ, .immediateB,
		.decPc, .decRs1, .decRs2,
		.outValid, .outReady,
		.programCounterInput, .branchALUOutput,
		.linkWrite, .branchALUBadFunct3
	);

endmodule

`default_nettype wire

/* source/branchALU.sv */
`default_nettype none

`include "rv32BranchUnit_params.svh"

module branchALU
(
	input logic clock,
	input logic arstN,

	// From the decode stage
	input logic decValid,
	output logic decReady,
	input branchUnitTypes::BranchALUMode_t branchALUMode,
	input branchUnitTypes::Funct3_t funct3,
	input branchUnitTypes::Word_t immediateI,
	input branchUnitTypes::Word_t immediateJ,
	input branchUnitTypes::Word_t immediateB,
	input branchUnitTypes::Word_t decPc,
	input branchUnitTypes::Word_t decRs1,
	input branchUnitTypes::Word_t decRs2,

	// Downstream side
	output logic outValid,
	input logic outReady,
	output branchUnitTypes::Word_t programCounterInput,
	output branchUnitTypes::Word_t branchALUOutput,
	output logic linkWrite,
	output logic branchALUBadFunct3
);

	branchUnitTypes::Word_t nextSequentialPc;
	branchUnitTypes::Word_t nextJalPc;
	branchUnitTypes::Word_t jalrSum;
	branchUnitTypes::Word_t nextJalrPc;
	branchUnitTypes::Word_t nextBranchPc;
	branchUnitTypes::Word_t nextPc;
	logic branchTaken;
	logic badFunct3;
	logic nextLinkWrite;
	logic loadOutput;

	// Target adders
	assign nextSequentialPc = decPc + branchUnitTypes::Word_t'(`PC_STEP);
	assign nextJalPc = decPc + immediateJ;
	assign jalrSum = decRs1 + immediateI;
	assign nextJalrPc = {jalrSum[`WORD_WIDTH - 1:1], 1'b0}; // ISA clears bit 0
	assign nextBranchPc = decPc + immediateB;

	// Branch comparator
	always_comb
	begin
		case (funct3)
			3'b000: branchTaken = decRs1 == decRs2; // beq
			3'b001: branchTaken = decRs1 != decRs2; // bne
			3'b100: branchTaken = $signed(decRs1) < $signed(decRs2); // blt
			3'b101: branchTaken = $signed(decRs1) >= $signed(decRs2); // bge
			3'b110: branchTaken = decRs1 < decRs2; // bltu
			3'b111: branchTaken = decRs1 >= decRs2; // bgeu
			default: branchTaken = 1'b0; // 010 and 011 never branch
		endcase
	end

	// Only branches care about funct3 here
	assign badFunct3 = (branchALUMode == branchUnitTypes::BRANCH) &&
		((funct3 == 3'b010) || (funct3 == 3'b011));

	// Next PC selection
	always_comb
	begin
		case (branchALUMode)
			branchUnitTypes::JAL: nextPc = nextJalPc;
			branchUnitTypes::JALR: nextPc = nextJalrPc;
			branchUnitTypes::BRANCH:
				nextPc = branchTaken ? nextBranchPc : nextSequentialPc;
			default: nextPc = nextSequentialPc; // INCREMENT
		endcase
	end

	// rd gets the return address for jumps
	assign nextLinkWrite = (branchALUMode == branchUnitTypes::JAL) ||
		(branchALUMode == branchUnitTypes::JALR);

	assign decReady = !outValid || outReady;
	assign loadOutput = decValid && decReady;

	always_ff @(posedge clock, negedge arstN)
	begin
		if (!arstN)
		begin
			outValid <= 1'b0;
			linkWrite <= 1'b0;
			branchALUBadFunct3 <= 1'b0;
		end
		else
		begin
			if (decReady)
				outValid <= decValid;
			if (loadOutput)
			begin
				linkWrite <= nextLinkWrite;
				branchALUBadFunct3 <= badFunct3;
			end
		end
	end

	// Result words
	always_ff @(posedge clock)
	begin
		if (loadOutput)
		begin
			programCounterInput <= nextPc;
			branchALUOutput <= nextSequentialPc; // Link value is always pc + 4
		end
	end

	// Decoder must hand over a known mode with every item
	property modeKnownWhenValid;
		@(posedge clock) disable iff (!arstN)
		decValid |-> !$isunknown(branchALUMode);
	endproperty

	assertModeKnown: assert property (modeKnownWhenValid)
	else
		$error("Unknown branch mode from decode stage");

endmodule

`default_nettype wire

/* source/branchDecoder.sv */
`default_nettype none

`include "rv32BranchUnit_params.svh"

module branchDecoder
(
	input logic clock,
	input logic arstN,

	// Upstream side
	input logic inValid,
	output logic inReady,
	input branchUnitTypes::Instruction_t instruction,
	input branchUnitTypes::Word_t pcOfInstruction,
	input branchUnitTypes::Word_t rs1,
	input branchUnitTypes::Word_t rs2,

	// Towards the branch stage
	output logic decValid,
	input logic decReady,
	output branchUnitTypes::BranchALUMode_t branchALUMode,
	output branchUnitTypes::Funct3_t funct3,
	output branchUnitTypes::Word_t immediateI,
	output branchUnitTypes::Word_t immediateJ,
	output branchUnitTypes::Word_t immediateB,
	output branchUnitTypes::Word_t decPc,
	output branchUnitTypes::Word_t decRs1,
	output branchUnitTypes::Word_t decRs2
);

	branchUnitTypes::Opcode_t opcode;
	branchUnitTypes::BranchALUMode_t nextMode;
	branchUnitTypes::Word_t nextImmediateI;
	branchUnitTypes::Word_t nextImmediateJ;
	branchUnitTypes::Word_t nextImmediateB;
	logic loadDecode;

	assign opcode = instruction[6:0];

	// Opcode to mode
	always_comb
	begin
		case (opcode)
			`OPCODE_JAL: nextMode = branchUnitTypes::JAL;
			`OPCODE_JALR: nextMode = branchUnitTypes::JALR;
			`OPCODE_BRANCH: nextMode = branchUnitTypes::BRANCH;
			default: nextMode = branchUnitTypes::INCREMENT; // Loads, stores, ALU ops, etc
		endcase
	end

	// Immediates, all sign extended from instruction bit 31
	assign nextImmediateI =
	{
		{(`WORD_WIDTH - 12){instruction[31]}},
		instruction[31:20]
	};

	assign nextImmediateJ =
	{
		{(`WORD_WIDTH - 21){instruction[31]}},
		instruction[31],
		instruction[19:12],
		instruction[20],
		instruction[30:21],
		1'b0 // Halfword aligned
	};

	assign nextImmediateB =
	{
		{(`WORD_WIDTH - 13){instruction[31]}},
		instruction[31],
		instruction[7],
		instruction[30:25],
		instruction[11:8],
		1'b0
	};

	// Empty register, or its item leaves this cycle
	assign inReady = !decValid || decReady;
	assign loadDecode = inValid && inReady;

	always_ff @(posedge clock, negedge arstN)
	begin
		if (!arstN)
			decValid <= 1'b0;
		else if (inReady)
			decValid <= inValid;
	end

	// Payload only changes on an accepted input
	always_ff @(posedge clock)
	begin
		if (loadDecode)
		begin
			branchALUMode <= nextMode;
			funct3 <= instruction[14:12];
			immediateI <= nextImmediateI;
			immediateJ <= nextImmediateJ;
			immediateB <= nextImmediateB;
			decPc <= pcOfInstruction;
			decRs1 <= rs1;
			decRs2 <= rs2;
		end
	end

	// A stalled item stays put until the branch stage takes it
	property decodeHeldWhileStalled;
		@(posedge clock) disable iff (!arstN)
		(decValid && !decReady) |=>
			(decValid &&
			$stable(branchALUMode) &&
			$stable(funct3) &&
			$stable(immediateI) &&
			$stable(immediateJ) &&
			$stable(immediateB) &&
			$stable(decPc) &&
			$stable(decRs1) &&
			$stable(decRs2));
	endproperty

	assertDecodeHeld: assert property (decodeHeldWhileStalled)
	else
		$error("Decode stage output changed while stalled");

endmodule

`default_nettype wire

/* source/branchUnitTypes.sv */
`default_nettype none

`include "rv32BranchUnit_params.svh"

package branchUnitTypes;

	// Register values, immediates and addresses
	typedef logic [`WORD_WIDTH - 1:0] Word_t;

	typedef logic [31:0] Instruction_t; // Always 32 bits in RV32I
	typedef logic [2:0] Funct3_t;
	typedef logic [6:0] Opcode_t;

	// How the branch stage forms the next PC
	typedef enum logic [1:0]
	{
		INCREMENT,
		JAL,
		JALR,
		BRANCH
	} BranchALUMode_t;

endpackage

`default_nettype wire

/* include/rv32BranchUnit_params.svh */
`ifndef RV32_BRANCH_UNIT_PARAMS_SVH
`define RV32_BRANCH_UNIT_PARAMS_SVH

// Data words and addresses
`define WORD_WIDTH 32

// Distance to the next instruction, no compressed set
`define PC_STEP 4

// RV32I control-flow opcodes
`define OPCODE_JAL 7'b1101111
`define OPCODE_JALR 7'b1100111
`define OPCODE_BRANCH 7'b1100011

`endif
